// File: design/axi_rd_pkg.sv
// AXI4 read protocol constants and channel payload structs for the read master
package axi_rd_pkg;

  ////////////////////////////////////////////////////////////
  // Interface widths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int DW_BYTES     = DATA_W / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  ////////////////////////////////////////////////////////////
  // Burst geometry
  ////////////////////////////////////////////////////////////

  // Protocol ceilings on a single INCR burst
  localparam int MAX_BURST_BEATS = 256;
  localparam int MAX_BURST_BYTES = 4096;

  // Beats per full burst as set by whichever ceiling is hit first
  localparam int BURST_LEN = (MAX_BURST_BYTES / DW_BYTES < MAX_BURST_BEATS) ?
                             MAX_BURST_BYTES / DW_BYTES : MAX_BURST_BEATS;
  localparam int LOG_BURST_LEN = $clog2(BURST_LEN);

  // Address stride between bursts and also the job alignment boundary
  localparam int BURST_BYTES = BURST_LEN * DW_BYTES;

  ////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////

  // AR request with len as beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } ar_req_t;

  // R beat that is reused unchanged on the stream side
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } r_beat_t;

endpackage : axi_rd_pkg

// File: design/axi_read_master.sv
// AXI4 read master top that splits a byte job into bursts and streams the read data out
`timescale 1ns/1ps

module axi_read_master
  import axi_rd_pkg::*, rd_cfg_pkg::*;
(
  input  logic      aclk,
  input  logic      areset,

  // Job control with single-cycle strobes
  input  logic      ctrl_start,
  input  ctrl_req_t ctrl_req,
  output logic      ctrl_done,

  // AXI4 read address channel
  output logic      m_axi_arvalid,
  input  logic      m_axi_arready,
  output ar_req_t   m_axi_ar,

  // AXI4 read data channel
  input  logic      m_axi_rvalid,
  output logic      m_axi_rready,
  input  r_beat_t   m_axi_r,

  // AXI4-Stream output
  output logic      m_axis_tvalid,
  input  logic      m_axis_tready,
  output r_beat_t   m_axis_t
);

  rd_job_t job;
  logic    job_start;
  logic    burst_drained;

  // FIFO always has room for every burst in flight
  assign m_axi_rready = 1'b1;

  ////////////////////////////////////////////////////////////
  // Job setup and AR side
  ////////////////////////////////////////////////////////////

  rd_job_setup u_setup (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .job        (job),
    .job_start  (job_start)
  );

  rd_addr_issuer u_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .job           (job),
    .job_start     (job_start),
    .burst_drained (burst_drained),
    .arready       (m_axi_arready),
    .arvalid       (m_axi_arvalid),
    .ar            (m_axi_ar)
  );

  ////////////////////////////////////////////////////////////
  // R side and stream
  ////////////////////////////////////////////////////////////

  rd_beat_tracker u_tracker (
    .aclk      (aclk),
    .areset    (areset),
    .job       (job),
    .job_start (job_start),
    .rvalid    (m_axi_rvalid),
    .rlast     (m_axi_r.last),
    .done      (ctrl_done)
  );

  // Every R beat is written since ready is never low
  rd_data_fifo u_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .wr_en         (m_axi_rvalid),
    .wr_data       (m_axi_r),
    .rd_ready      (m_axis_tready),
    .rd_valid      (m_axis_tvalid),
    .rd_data       (m_axis_t),
    .burst_drained (burst_drained)
  );

endmodule : axi_read_master

// File: design/rd_addr_issuer.sv
// AR channel issuer that steps burst addresses and holds bursts in flight to the credit limit
`timescale 1ns/1ps

module rd_addr_issuer
  import axi_rd_pkg::*, rd_cfg_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  rd_job_t job,
  input  logic    job_start,
  input  logic    burst_drained,
  input  logic    arready,
  output logic    arvalid,
  output ar_req_t ar
);

  logic              idle;
  logic              arxfer;
  logic              ar_final;
  logic              ar_done;
  logic              no_credit;
  logic [OUTST_W-1:0] credit_cnt;
  logic [ADDR_W-1:0] addr_q;

  assign arxfer  = arvalid & arready;
  assign ar_done = arxfer & ar_final;

  ////////////////////////////////////////////////////////////
  // Issue control
  ////////////////////////////////////////////////////////////

  // Busy from job start until the final AR handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
    end else if (job_start) begin
      idle <= 1'b0;
    end else if (ar_done) begin
      idle <= 1'b1;
    end
  end

  // Valid drops for one cycle after each handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!idle && !no_credit && !arvalid) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // Next burst address only moves on a handshake
  always_ff @(posedge aclk) begin
    if (job_start) begin
      addr_q <= job.base_addr;
    end else if (arxfer) begin
      addr_q <= addr_q + ADDR_W'(BURST_BYTES);
    end
  end

  assign ar.addr = addr_q;
  assign ar.len  = ar_final ? job.final_len : 8'(BURST_LEN - 1);

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  // Bursts left before the final one
  txn_counter #(
    .WIDTH (TXN_W),
    .INIT  ('0)
  ) u_ar_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (job_start),
    .incr       (1'b0),
    .decr       (arxfer),
    .load_value (job.num_txn),
    .count      (),
    .is_zero    (ar_final)
  );

  // Free slots that are handed back as bursts leave the FIFO
  txn_counter #(
    .WIDTH (OUTST_W),
    .INIT  (OUTST_W'(MAX_OUTSTANDING))
  ) u_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_drained),
    .decr       (arxfer),
    .load_value ('0),
    .count      (credit_cnt),
    .is_zero    (no_credit)
  );

  // Payload must hold through a stall
  a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(ar));

  // More credit than slots means a drain without a matching burst
  a_credit_max: assert property (@(posedge aclk) disable iff (areset)
    credit_cnt <= OUTST_W'(MAX_OUTSTANDING));

endmodule : rd_addr_issuer

// File: design/rd_beat_tracker.sv
// R channel tracker that counts finished bursts and pulses done after the final last beat
`timescale 1ns/1ps

module rd_beat_tracker
  import rd_cfg_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  rd_job_t job,
  input  logic    job_start,
  input  logic    rvalid,
  input  logic    rlast,
  output logic    done
);

  logic             idle;
  logic             burst_end;
  logic             r_final;
  logic             job_end;

  // Ready is tied high so valid alone marks an accepted beat
  assign burst_end = rvalid & rlast;
  assign job_end   = burst_end & r_final & ~idle;

  // Bursts still to complete before the final one
  txn_counter #(
    .WIDTH (TXN_W),
    .INIT  ('0)
  ) u_r_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (job_start),
    .incr       (1'b0),
    .decr       (burst_end),
    .load_value (job.num_txn),
    .count      (),
    .is_zero    (r_final)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
      done <= 1'b0;
    end else begin
      // Single-cycle pulse on the edge that takes the last beat
      done <= job_end;
      if (job_start) begin
        idle <= 1'b0;
      end else if (job_end) begin
        idle <= 1'b1;
      end
    end
  end

  // Beats only come back for bursts of an active job
  a_r_idle: assert property (@(posedge aclk) disable iff (areset)
    rvalid |-> !idle);

endmodule : rd_beat_tracker

// File: design/rd_cfg_pkg.sv
// Read master configuration with credit limit, counter widths, FIFO sizing and job structs
package rd_cfg_pkg;

  import axi_rd_pkg::*;

  ////////////////////////////////////////////////////////////
  // Job sizing
  ////////////////////////////////////////////////////////////

  // Byte count width on the control port
  localparam int XFER_W = 16;

  // Beats minus one for a whole job
  localparam int TOTAL_LEN_W = XFER_W - LOG_DW_BYTES;

  // Full bursts ahead of the final one
  localparam int TXN_W = TOTAL_LEN_W - LOG_BURST_LEN;

  ////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////

  localparam int MAX_OUTSTANDING = 4;
  // Holds 0 up to MAX_OUTSTANDING inclusive
  localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

  // Room for every outstanding burst rounded up to a power of two
  localparam int FIFO_DEPTH = 2 ** $clog2(BURST_LEN * MAX_OUTSTANDING);
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////
  // Request and job records
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr_offset;
    logic [XFER_W-1:0] xfer_size;
  } ctrl_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0]        base_addr;
    logic [TXN_W-1:0]         num_txn;
    logic [LOG_BURST_LEN-1:0] final_len;
  } rd_job_t;

endpackage : rd_cfg_pkg

// File: design/rd_data_fifo.sv
// Synchronous FWFT FIFO buffering R beats toward the stream output
`timescale 1ns/1ps

module rd_data_fifo
  import axi_rd_pkg::*, rd_cfg_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  logic    wr_en,
  input  r_beat_t wr_data,
  input  logic    rd_ready,
  output logic    rd_valid,
  output r_beat_t rd_data,
  output logic    burst_drained
);

  r_beat_t mem [FIFO_DEPTH];

  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic [FIFO_AW:0] fill;
  r_beat_t          ram_q;
  logic             ram_q_valid;
  logic             ram_rd;
  logic             out_load;
  logic             rd_fire;
  logic             full;

  ////////////////////////////////////////////////////////////
  // Pipeline control
  ////////////////////////////////////////////////////////////

  assign rd_fire  = rd_valid & rd_ready;
  // Output register takes the RAM stage when empty or being drained
  assign out_load = ram_q_valid & (~rd_valid | rd_ready);
  // RAM read when words wait and the read stage frees up
  assign ram_rd   = (wr_ptr != rd_ptr) & (~ram_q_valid | out_load);

  // Counts everything held in the RAM and both stages
  assign full = (fill == (FIFO_AW + 1)'(FIFO_DEPTH));

  assign burst_drained = rd_fire & rd_data.last;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
    end
  end

  // Registered read followed by the output register
  always_ff @(posedge aclk) begin
    if (ram_rd) begin
      ram_q <= mem[rd_ptr[FIFO_AW-1:0]];
    end
    if (out_load) begin
      rd_data <= ram_q;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill        <= '0;
      ram_q_valid <= 1'b0;
      rd_valid    <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ram_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + (FIFO_AW + 1)'(wr_en) - (FIFO_AW + 1)'(rd_fire);
      if (ram_rd) begin
        ram_q_valid <= 1'b1;
      end else if (out_load) begin
        ram_q_valid <= 1'b0;
      end
      if (out_load) begin
        rd_valid <= 1'b1;
      end else if (rd_fire) begin
        rd_valid <= 1'b0;
      end
    end
  end

  // Credit limit upstream keeps writes off a full buffer
  a_no_overflow: assert property (@(posedge aclk) disable iff (areset)
    wr_en |-> !full);

endmodule : rd_data_fifo

// File: design/rd_job_setup.sv
// Job setup that captures a read request, aligns and rounds it, and strobes job start
`timescale 1ns/1ps

module rd_job_setup
  import axi_rd_pkg::*, rd_cfg_pkg::*;
(
  input  logic      aclk,
  input  logic      areset,
  input  logic      ctrl_start,
  input  ctrl_req_t ctrl_req,
  output rd_job_t   job,
  output logic      job_start
);

  ////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] ADDR_MASK = ADDR_W'(BURST_BYTES - 1);

  logic [ADDR_W-1:0]      base_addr_q;
  logic [TOTAL_LEN_W-1:0] total_len_q;
  logic [TOTAL_LEN_W-1:0] size_beats;
  logic                   start_d1;

  // Whole beats in the byte count without any partial tail
  assign size_beats = ctrl_req.xfer_size[LOG_DW_BYTES +: TOTAL_LEN_W];

  // Beats minus one after rounding up to whole beats
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      if (ctrl_req.xfer_size[LOG_DW_BYTES-1:0] != '0) begin
        total_len_q <= size_beats;
      end else begin
        total_len_q <= size_beats - 1'b1;
      end
      // Align down to the burst stride
      base_addr_q <= ctrl_req.addr_offset & ~ADDR_MASK;
    end
  end

  ////////////////////////////////////////////////////////////
  // Job split and start strobe
  ////////////////////////////////////////////////////////////

  // Upper bits count full bursts and lower bits are the final burst's len
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      job.base_addr <= base_addr_q;
      job.num_txn   <= total_len_q[LOG_BURST_LEN +: TXN_W];
      job.final_len <= total_len_q[LOG_BURST_LEN-1:0];
    end
  end

  // Two-stage delay so the job is already valid when the strobe shows
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1  <= 1'b0;
      job_start <= 1'b0;
    end else begin
      start_d1  <= ctrl_start;
      job_start <= start_d1;
    end
  end

endmodule : rd_job_setup

// File: design/txn_counter.sv
// Loadable up/down counter with zero flag for burst and credit bookkeeping
`timescale 1ns/1ps

module txn_counter #(
  parameter int               WIDTH = 4,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  logic [WIDTH-1:0] count_q;

  // Load wins over any step
  // Simultaneous incr and decr cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count_q <= INIT;
    end else if (load) begin
      count_q <= load_value;
    end else if (incr && !decr) begin
      count_q <= count_q + 1'b1;
    end else if (decr && !incr) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count = count_q;

  // Flag follows the register directly with no extra cycle
  assign is_zero = (count_q == '0);

endmodule : txn_counter

// File: files.f
design/axi_rd_pkg.sv
design/rd_cfg_pkg.sv
design/txn_counter.sv
design/rd_job_setup.sv
design/rd_addr_issuer.sv
design/rd_beat_tracker.sv
design/rd_data_fifo.sv
design/axi_read_master.sv
verif/rd_checker.sv
verif/tb_axi_read_master.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read master testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_axi_read_master \
  -o tb_axi_read_master > sim.log 2>&1 \
  && ./obj_dir/tb_axi_read_master >> sim.log 2>&1 \
  || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: verif/rd_checker.sv
// Scoreboard for the read master that models each job and checks AR, stream, credit and done
`timescale 1ns/1ps

module rd_checker
  import axi_rd_pkg::*, rd_cfg_pkg::*;
#(
  parameter logic [31:0] DATA_XOR = 32'h5a5a_5a5a
) (
  input  logic      aclk,
  input  logic      areset,
  input  logic      ctrl_start,
  input  ctrl_req_t ctrl_req,
  input  logic      ctrl_done,
  input  logic      arvalid,
  input  logic      arready,
  input  ar_req_t   ar,
  input  logic      rvalid,
  input  logic      rready,
  input  logic      tvalid,
  input  logic      tready,
  input  r_beat_t   t,
  output int        errors,
  output int        checks,
  output int        stream_beats
);

  // Job geometry of 4-byte beats in 256-beat bursts on a 1 KiB stride
  localparam int BEAT_BYTES  = 4;
  localparam int BURST_BEATS = 256;
  localparam int STRIDE      = 1024;
  localparam int OUTST_LIMIT = 4;

  logic [31:0] exp_data [$];
  logic        exp_last [$];
  ar_req_t     exp_ar [$];
  int          job_beats [$];
  ar_req_t     next_ar;
  int          r_count;
  int          outstanding;
  logic        done_due;
  logic        job_seen;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic fault(input string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model turning one request into beats and bursts
  ////////////////////////////////////////////////////////////

  task automatic add_job(input ctrl_req_t req);
    logic [31:0] base;
    int          beats;
    int          bursts;
    ar_req_t     burst;
    base   = req.addr_offset & ~32'(STRIDE - 1);
    beats  = (int'(req.xfer_size) + BEAT_BYTES - 1) / BEAT_BYTES;
    bursts = (beats + BURST_BEATS - 1) / BURST_BEATS;
    for (int i = 0; i < beats; i++) begin
      exp_data.push_back((base + 32'(i * BEAT_BYTES)) ^ DATA_XOR);
      // Last on every full burst boundary and on the job's tail
      exp_last.push_back(((i + 1) % BURST_BEATS == 0) || (i == beats - 1));
    end
    for (int k = 0; k < bursts; k++) begin
      burst.addr = base + 32'(k * STRIDE);
      burst.len  = (k == bursts - 1) ? 8'(beats - 1 - k * BURST_BEATS) : 8'(BURST_BEATS - 1);
      exp_ar.push_back(burst);
    end
    job_beats.push_back(beats);
  endtask

  ////////////////////////////////////////////////////////////
  // Port monitor
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      exp_data.delete();
      exp_last.delete();
      exp_ar.delete();
      job_beats.delete();
      errors       = 0;
      checks       = 0;
      stream_beats = 0;
      r_count      = 0;
      outstanding  = 0;
      done_due     = 1'b0;
      job_seen     = 1'b0;
    end else begin
      // Quiet bus until the first request
      if (!job_seen) begin
        compare("m_axi_arvalid", 32'(arvalid), 32'd0);
        compare("m_axis_tvalid", 32'(tvalid), 32'd0);
      end
      // R channel never pushes back
      compare("m_axi_rready", 32'(rready), 32'd1);
      if (ctrl_start) begin
        job_seen = 1'b1;
        add_job(ctrl_req);
      end
      // Done is due one edge after the job's final R beat, and only then
      compare("ctrl_done", 32'(ctrl_done), 32'(done_due));
      done_due = 1'b0;
      if (arvalid && arready) begin
        outstanding++;
        if (exp_ar.size() == 0) begin
          fault("AR request accepted with no burst left in any job");
        end else begin
          next_ar = exp_ar.pop_front();
          compare("m_axi_ar.addr", ar.addr, next_ar.addr);
          compare("m_axi_ar.len", 32'(ar.len), 32'(next_ar.len));
        end
      end
      if (rvalid && rready) begin
        if (job_beats.size() == 0) begin
          fault("R beat arrived with no job active");
        end else begin
          r_count++;
          if (r_count == job_beats[0]) begin
            done_due = 1'b1;
            r_count  = 0;
            void'(job_beats.pop_front());
          end
        end
      end
      if (tvalid && tready) begin
        stream_beats++;
        if (exp_data.size() == 0) begin
          fault("Stream beat delivered with no data expected");
        end else begin
          compare("m_axis_t.data", t.data, exp_data.pop_front());
          compare("m_axis_t.last", 32'(t.last), 32'(exp_last.pop_front()));
        end
        // A burst leaves the outstanding set once its last beat is consumed
        if (t.last) begin
          outstanding--;
        end
      end
      if (outstanding > OUTST_LIMIT) begin
        fault($sformatf("%0d bursts outstanding, the limit is four", outstanding));
      end
    end
  end

endmodule : rd_checker

// File: verif/tb_axi_read_master.sv
// Testbench for the AXI4 read master with random slave, stream sink, job sequencing and timeout
`timescale 1ns/1ps

module tb_axi_read_master
  import axi_rd_pkg::*, rd_cfg_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // Run constants
  ////////////////////////////////////////////////////////////

  localparam logic [31:0] SEED           = 32'h9231ec35;
  localparam int          NUM_JOBS       = 20;
  localparam int          MAX_SIZE       = 6000;
  localparam logic [31:0] DATA_XOR       = 32'h5a5a_5a5a;
  // Cycles allowed per beat and a fixed margin
  localparam int          TIMEOUT_FACTOR = 8;
  localparam int          TIMEOUT_BASE   = 2000;
  // Long tready stall when this many random bits are all ones
  localparam int          STALL_BITS     = 12;
  localparam int          STALL_MIN      = 1024;
  localparam int          STALL_LEN_BITS = 11;

  logic        aclk = 1'b0;
  logic        areset;
  logic        ctrl_start;
  ctrl_req_t   ctrl_req;
  logic        ctrl_done;
  logic        m_axi_arvalid;
  logic        m_axi_arready;
  ar_req_t     m_axi_ar;
  logic        m_axi_rvalid;
  logic        m_axi_rready;
  r_beat_t     m_axi_r;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  r_beat_t     m_axis_t;

  logic [31:0] lfsr_state;
  logic [31:0] job_addr [NUM_JOBS];
  logic [15:0] job_size [NUM_JOBS];
  int          total_beats;
  int          timeout_limit;
  int          cycle_count = 0;
  int          job_idx;
  logic        job_busy;
  int          errors;
  int          checks;
  int          stream_beats;

  // Slave model state
  logic        ar_seen;
  ar_req_t     ar_seen_req;
  ar_req_t     burst_q [$];
  logic        r_active;
  logic [31:0] r_addr;
  logic [7:0]  r_left;
  int          stall_left;

  always #2 aclk = ~aclk;

  axi_read_master u_dut (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_req      (ctrl_req),
    .ctrl_done     (ctrl_done),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_ar      (m_axi_ar),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_r       (m_axi_r),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_t      (m_axis_t)
  );

  rd_checker #(
    .DATA_XOR (DATA_XOR)
  ) u_chk (
    .aclk         (aclk),
    .areset       (areset),
    .ctrl_start   (ctrl_start),
    .ctrl_req     (ctrl_req),
    .ctrl_done    (ctrl_done),
    .arvalid      (m_axi_arvalid),
    .arready      (m_axi_arready),
    .ar           (m_axi_ar),
    .rvalid       (m_axi_rvalid),
    .rready       (m_axi_rready),
    .tvalid       (m_axis_tvalid),
    .tready       (m_axis_tready),
    .t            (m_axis_t),
    .errors       (errors),
    .checks       (checks),
    .stream_beats (stream_beats)
  );

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Falling-edge drivers
  ////////////////////////////////////////////////////////////

  // Next job goes out only after the previous done
  task automatic sequence_jobs();
    ctrl_start = 1'b0;
    if (job_busy && ctrl_done) begin
      job_busy = 1'b0;
      job_idx++;
    end else if (!job_busy && job_idx < NUM_JOBS) begin
      ctrl_start           = 1'b1;
      ctrl_req.addr_offset = job_addr[job_idx];
      ctrl_req.xfer_size   = job_size[job_idx];
      job_busy             = 1'b1;
    end
  endtask

  task automatic model_slave();
    ar_req_t     next_burst;
    logic [31:0] pick;
    // Beat on the bus was taken at the last rising edge
    if (m_axi_rvalid && m_axi_rready) begin
      r_addr = r_addr + 32'd4;
      if (r_left == 8'd0) begin
        r_active = 1'b0;
      end else begin
        r_left = r_left - 8'd1;
      end
    end
    if (ar_seen) begin
      burst_q.push_back(ar_seen_req);
    end
    if (!r_active && burst_q.size() > 0) begin
      next_burst = burst_q.pop_front();
      r_addr     = next_burst.addr;
      r_left     = next_burst.len;
      r_active   = 1'b1;
    end
    // Data is the byte address XOR a fixed pattern
    pick = rand_bits(2);
    if (r_active && pick != '0) begin
      m_axi_rvalid   = 1'b1;
      m_axi_r.data   = r_addr ^ DATA_XOR;
      m_axi_r.last   = (r_left == 8'd0);
    end else begin
      m_axi_rvalid = 1'b0;
    end
    m_axi_arready = (rand_bits(2) != '0);
  endtask

  // Mostly random ready with now and then a stall long enough to fill the FIFO
  task automatic pace_stream();
    logic [31:0] pick;
    if (stall_left > 0) begin
      m_axis_tready = 1'b0;
      stall_left--;
    end else begin
      pick = rand_bits(STALL_BITS);
      if (pick == 32'((1 << STALL_BITS) - 1)) begin
        stall_left    = STALL_MIN + int'(rand_bits(STALL_LEN_BITS));
        m_axis_tready = 1'b0;
      end else begin
        m_axis_tready = (rand_bits(2) != '0);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequencing, timeout and verdict
  ////////////////////////////////////////////////////////////

  task automatic finish_run(input logic timed_out);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, 32'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // AR handshakes caught at the rising edge for the slave model
  always @(posedge aclk) begin
    ar_seen     <= !areset && m_axi_arvalid && m_axi_arready;
    ar_seen_req <= m_axi_ar;
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: run still busy after %0d cycles", timeout_limit);
      finish_run(1'b1);
    end
  end

  initial begin
    lfsr_state    = SEED;
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_req      = '0;
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_r       = '0;
    m_axis_tready = 1'b0;
    r_active      = 1'b0;
    r_addr        = '0;
    r_left        = '0;
    stall_left    = 0;
    job_idx       = 0;
    job_busy      = 1'b0;
    total_beats   = 0;
    timeout_limit = 0;
    // All jobs drawn up front so the budget is known
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_addr[j] = rand_bits(32);
      job_size[j] = 16'((rand_bits(13) % MAX_SIZE) + 1);
      total_beats += (int'(job_size[j]) + 3) / 4;
    end
    timeout_limit = total_beats * TIMEOUT_FACTOR + TIMEOUT_BASE;
    repeat (5) @(negedge aclk);
    areset = 1'b0;
    // Idle window before the first job
    repeat (4) @(negedge aclk);
    while (job_idx < NUM_JOBS || stream_beats < total_beats) begin
      @(negedge aclk);
      sequence_jobs();
      model_slave();
      pace_stream();
    end
    repeat (4) @(negedge aclk);
    finish_run(1'b0);
  end

endmodule : tb_axi_read_master
